/* include/weight_rotator_cfg.svh */
`ifndef WEIGHT_ROTATOR_CFG_SVH
`define WEIGHT_ROTATOR_CFG_SVH

////////////////////
// line shape
////////////////////

// bits per weight
`define WR_DATA_WIDTH 16
// conv cores fed in parallel
`define WR_CONV_CORES 1
// kernel taps per core and line
`define WR_LANES 3

////////////////////
// bank geometry
////////////////////

// block ram address, about 1024 ch * 3 + bias
`define WR_ADDR_WIDTH 12
`define WR_RAM_DEPTH (1 << `WR_ADDR_WIDTH)
// replay pass counter, width * blocks
`define WR_ROTATE_WIDTH 14

// lines prefetched into the fifo while a group loads
`define WR_FIFO_DEPTH 4
// bank read latency in cycles
`define WR_RAM_LATENCY 2

////////////////////
// layer geometry
////////////////////

`define WR_CH_WIDTH 10
`define WR_IMW_WIDTH 9
`define WR_BLK_WIDTH 5

`endif

/* hdl/weight_rotator_pkg.sv */
`include "weight_rotator_cfg.svh"

package weight_rotator_pkg;

    ////////////////////
    // data types
    ////////////////////

    typedef logic [`WR_DATA_WIDTH-1:0] weight_t;  // one kernel tap

    // all lanes of all cores, lane 0 in the low bits
    typedef weight_t [`WR_CONV_CORES*`WR_LANES-1:0] weight_line_t;

    // side-band of a layer, every count given as value - 1
    typedef struct packed {
        logic [`WR_CH_WIDTH-1:0]  channels;   // input channels
        logic [`WR_IMW_WIDTH-1:0] width;      // image width
        logic [`WR_BLK_WIDTH-1:0] blocks;     // row blocks
        logic                     conv_mode;  // 0: 3x3 kernel
        logic                     max_mode;   // max pool after conv
    } layer_cfg_t;

    // value seen on cfg_out out of reset
    localparam layer_cfg_t LAYER_CFG_RESET = '{
        channels:  '0,
        width:     '0,
        blocks:    '0,
        conv_mode: 1'b0,
        max_mode:  1'b1
    };

    // replay limits taken over at the bank switch
    typedef struct packed {
        logic [`WR_ADDR_WIDTH-1:0]   last_addr;  // last weight line of the group
        logic [`WR_ROTATE_WIDTH-1:0] passes;     // replays - 1
    } replay_cfg_t;

    ////////////////////
    // control types
    ////////////////////

    typedef enum logic {
        ROT_IDLE,    // nothing left to issue
        ROT_STREAM   // issuing bank reads
    } rot_state_t;

endpackage

/* hdl/weight_ram.sv */
`timescale 1ns/1ps
`include "weight_rotator_cfg.svh"

// one ping-pong bank, stands in for a single port block ram
module weight_ram (
    input  logic                             clk,
    input  logic                             we,
    input  logic [`WR_ADDR_WIDTH-1:0]        addr,
    input  weight_rotator_pkg::weight_line_t wdata,
    output weight_rotator_pkg::weight_line_t rdata
);
    import weight_rotator_pkg::*;

    localparam int LAT = `WR_RAM_LATENCY;

    weight_line_t mem [`WR_RAM_DEPTH];   // bank storage
    weight_line_t rd_stage [LAT];        // output register chain

    // read first, old contents come out on a collision
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rd_stage[0] <= mem[addr];       // address sampled here
        for (int i = 1; i < LAT; i++) begin
            rd_stage[i] <= rd_stage[i-1];   // extra output regs
        end
    end

    assign rdata = rd_stage[LAT-1];   // LAT cycles after addr

endmodule

/* hdl/weight_fifo.sv */
`timescale 1ns/1ps
`include "weight_rotator_cfg.svh"

// prefetch fifo in front of one bank
module weight_fifo (
    input  logic                             clk,
    input  logic                             rstn,
    input  weight_rotator_pkg::weight_line_t din,
    input  logic                             we,
    input  logic                             re,
    output logic                             l_rdy,
    output logic                             r_valid,
    output logic                             last_data,
    output weight_rotator_pkg::weight_line_t dout
);
    import weight_rotator_pkg::*;

    localparam int DEPTH = `WR_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    weight_line_t     mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;    // entries held
    logic             push;
    logic             pop;

    // circular increment, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    ////////////////////
    // flags
    ////////////////////

    assign l_rdy     = (fill != CNT_W'(DEPTH));   // room for one more
    assign r_valid   = (fill != '0);
    assign last_data = (fill == CNT_W'(1));       // one entry left

    assign push = we & l_rdy;    // writes into a full fifo are dropped
    assign pop  = re & r_valid;

    // head entry, steady while not popped
    assign dout = mem[rd_ptr];

    ////////////////////
    // storage
    ////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;       // idle, or push and pop together
            endcase
        end
    end

endmodule

/* hdl/weight_rotator.sv */
`timescale 1ns/1ps
`include "weight_rotator_cfg.svh"

// two banks: one loads the next kernel group while the other replays
module weight_rotator (
    input  logic                             clk,
    input  logic                             rstn,
    // load side
    input  weight_rotator_pkg::weight_line_t din,
    input  logic                             l_valid,
    input  logic [`WR_ADDR_WIDTH-1:0]        write_depth,    // index of the bias line
    input  logic [`WR_ROTATE_WIDTH-1:0]      rotate_amount,  // replays - 1
    input  weight_rotator_pkg::layer_cfg_t   cfg_in,         // taken with the bias line
    output logic                             l_rdy,
    // replay side
    input  logic                             r_rdy,
    output logic                             r_valid,
    output weight_rotator_pkg::weight_line_t dout,
    // side-band, changes only at a bank switch
    output weight_rotator_pkg::weight_line_t bias_out,
    output weight_rotator_pkg::layer_cfg_t   cfg_out,
    output logic                             is_3x3
);
    import weight_rotator_pkg::*;

    localparam int LAT = `WR_RAM_LATENCY;

    // lines below this address come out of the prefetch fifo
    localparam logic [`WR_ADDR_WIDTH-1:0] FIRST_ADDR = `WR_FIFO_DEPTH;

    ////////////////////
    // declarations
    ////////////////////

    // load side
    logic                      wr_bank;      // bank being written, other one replays
    logic [`WR_ADDR_WIDTH-1:0] wr_addr;
    logic                      wr_fire;
    logic                      wr_at_bias;   // next accepted line is the bias
    logic                      wr_prefetch;  // line also goes to the fifo

    // latched at the switch
    weight_line_t bias_q;
    layer_cfg_t   cfg_q;
    replay_cfg_t  rcfg_q;

    // replay side
    rot_state_t                  state;
    rot_state_t                  state_nxt;
    logic                        rot_sel;    // copy of wr_bank once replay has started
    logic                        rd_bank;
    logic [`WR_ADDR_WIDTH-1:0]   rd_addr;
    logic [`WR_ROTATE_WIDTH-1:0] pass_cnt;
    logic                        rd_pop;
    logic                        rot_start;
    logic                        rd_busy;
    logic                        rd_issue;   // bank read goes out this cycle
    logic                        rd_wrap;
    logic                        rd_done;
    logic                        rd_drained;
    logic                        rd_last_data;
    logic [LAT-1:0]              rd_pipe;    // issue delayed to match ram latency

    // per bank
    logic [1:0]                ram_we;
    logic [`WR_ADDR_WIDTH-1:0] ram_addr [2];
    weight_line_t              ram_rdata [2];
    logic [1:0]                fifo_we;
    weight_line_t              fifo_din [2];
    logic [1:0]                fifo_re;
    logic [1:0]                fifo_rdy;
    logic [1:0]                fifo_valid;
    logic [1:0]                fifo_last;
    weight_line_t              fifo_dout [2];

    ////////////////////
    // load side
    ////////////////////

    assign rd_bank     = ~wr_bank;
    assign wr_fire     = l_valid & l_rdy;
    assign wr_at_bias  = (wr_addr == write_depth);
    assign wr_prefetch = (wr_addr < FIRST_ADDR);

    // read bank is drained once nothing is left to issue, nothing is in
    // flight and its fifo empties on this edge
    assign rd_drained = ~rd_busy & ~|rd_pipe
                      & (~r_valid | (rd_last_data & r_rdy));

    // the bias line holds until the read bank lets go
    assign l_rdy = wr_at_bias ? rd_drained : (~wr_prefetch | fifo_rdy[wr_bank]);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_addr <= '0;
            wr_bank <= 1'b0;           // bank A loads first
            bias_q  <= '0;
            cfg_q   <= LAYER_CFG_RESET;
            rcfg_q  <= '0;
        end else if (wr_fire) begin
            if (wr_at_bias) begin      // group complete, swap banks
                wr_addr <= '0;
                wr_bank <= ~wr_bank;
                bias_q  <= din;
                cfg_q   <= cfg_in;
                rcfg_q  <= '{last_addr: write_depth - 1'b1, passes: rotate_amount};
            end else begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    ////////////////////
    // replay fsm
    ////////////////////

    assign rd_pop    = r_rdy & r_valid;
    assign rot_start = (state == ROT_IDLE) & (wr_bank != rot_sel);  // fresh group
    assign rd_busy   = (state == ROT_STREAM) | rot_start;
    assign rd_issue  = rd_pop & rd_busy;   // one read per line leaving the fifo
    assign rd_wrap   = (rd_addr == rcfg_q.last_addr);
    assign rd_done   = rd_issue & rd_wrap & (pass_cnt == rcfg_q.passes);

    always_comb begin
        state_nxt = state;
        case (state)
            ROT_IDLE: begin
                if (rot_start) begin
                    state_nxt = ROT_STREAM;
                end
            end
            ROT_STREAM: state_nxt = ROT_STREAM;   // left only through rd_done
            default:    state_nxt = ROT_IDLE;
        endcase
        if (rd_done) begin
            state_nxt = ROT_IDLE;   // also covers a single read group
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= ROT_IDLE;
            rot_sel  <= 1'b0;
            rd_addr  <= FIRST_ADDR;   // lines below sit in the fifo
            pass_cnt <= '0;
            rd_pipe  <= '0;
        end else begin
            state   <= state_nxt;
            rd_pipe <= LAT'({rd_pipe, rd_issue});   // shift in, oldest drops out
            if (rot_start) begin
                rot_sel <= wr_bank;
            end
            if (rd_issue) begin
                if (rd_done) begin
                    rd_addr  <= FIRST_ADDR;   // ready for the next group
                    pass_cnt <= '0;
                end else if (rd_wrap) begin
                    rd_addr  <= '0;           // later passes read from the bank only
                    pass_cnt <= pass_cnt + 1'b1;
                end else begin
                    rd_addr <= rd_addr + 1'b1;
                end
            end
        end
    end

    ////////////////////
    // banks
    ////////////////////

    for (genvar b = 0; b < 2; b++) begin : g_bank
        logic is_wr;

        assign is_wr = (wr_bank == 1'(b));

        assign ram_we[b]   = is_wr & wr_fire & ~wr_at_bias;   // bias stays in regs
        assign ram_addr[b] = is_wr ? wr_addr : rd_addr;

        // prefetch straight from din, replay from the bank
        assign fifo_we[b]  = is_wr ? (wr_fire & wr_prefetch) : rd_pipe[LAT-1];
        assign fifo_din[b] = is_wr ? din : ram_rdata[b];
        assign fifo_re[b]  = ~is_wr & r_rdy;

        weight_ram u_ram (
            .clk   (clk),
            .we    (ram_we[b]),
            .addr  (ram_addr[b]),
            .wdata (din),
            .rdata (ram_rdata[b])
        );

        weight_fifo u_fifo (
            .clk       (clk),
            .rstn      (rstn),
            .din       (fifo_din[b]),
            .we        (fifo_we[b]),
            .re        (fifo_re[b]),
            .l_rdy     (fifo_rdy[b]),
            .r_valid   (fifo_valid[b]),
            .last_data (fifo_last[b]),
            .dout      (fifo_dout[b])
        );
    end

    ////////////////////
    // outputs
    ////////////////////

    assign rd_last_data = fifo_last[rd_bank];
    assign r_valid      = fifo_valid[rd_bank];
    assign dout         = fifo_dout[rd_bank];

    assign bias_out = bias_q;
    assign cfg_out  = cfg_q;
    assign is_3x3   = ~cfg_q.conv_mode;   // conv_mode 0 is 3x3

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

// free running clock and power-on reset for the testbench
module tb_clock_gen (
    output logic clk,
    output logic rstn
);
    localparam real HALF_NS    = 2.0;   // 4 ns period
    localparam int  RST_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #(HALF_NS) clk = ~clk;
    end

    initial begin
        rstn = 1'b0;                    // asserted from time 0
        repeat (RST_CYCLES) @(posedge clk);
        #0.5;
        rstn = 1'b1;                    // released with the other inputs
    end

endmodule

/* verification/tb_weight_rotator.sv */
`timescale 1ns/1ps
`include "weight_rotator_cfg.svh"

module tb_weight_rotator;
    import weight_rotator_pkg::*;

    // lines in + lines out + settling per test, back-pressure test counted twice
    localparam int TEST_CYCLES = 12 + (7 + 18 + 8) + (6 + 10 + 8) + (14 + 38 + 8)
                               + 2 * (13 + 27 + 8);
    localparam int WATCHDOG_NS = TEST_CYCLES * 4 * 3;   // 4 ns clock, 3x margin

    logic                        clk;
    logic                        rstn;
    weight_line_t                din;
    logic                        l_valid;
    logic [`WR_ADDR_WIDTH-1:0]   write_depth;
    logic [`WR_ROTATE_WIDTH-1:0] rotate_amount;
    layer_cfg_t                  cfg_in;
    logic                        r_rdy;
    logic                        l_rdy;
    logic                        r_valid;
    weight_line_t                dout;
    weight_line_t                bias_out;
    layer_cfg_t                  cfg_out;
    logic                        is_3x3;

    ////////////////////
    // reference model state
    ////////////////////

    integer       seed = 74974;
    weight_line_t grp_q[$];     // weight lines of the group being loaded
    weight_line_t exp_q[$];     // lines still due on dout, in order
    int           exp_cnt;
    weight_line_t exp_head;
    weight_line_t exp_bias;
    layer_cfg_t   exp_cfg;
    int           l_idx;        // next line index on the load side
    logic         l_take;       // transfers seen mid-cycle, applied a cycle later
    logic         l_bias;
    weight_line_t l_line;
    layer_cfg_t   l_cfg;
    logic [`WR_ROTATE_WIDTH-1:0] l_rot;
    logic         r_take;
    logic         stall_cur;
    logic         stall_prev;
    weight_line_t dout_cur;
    weight_line_t dout_prev;
    logic         rand_rdy;
    logic         rdy_next;
    int           out_cnt;
    int           err_cnt;
    int           errs_at_start;
    int           n_tests;
    int           n_failed;

    tb_clock_gen clk_gen (.clk(clk), .rstn(rstn));

    weight_rotator DUT (
        .clk(clk), .rstn(rstn),
        .din(din), .l_valid(l_valid), .write_depth(write_depth),
        .rotate_amount(rotate_amount), .cfg_in(cfg_in), .l_rdy(l_rdy),
        .r_rdy(r_rdy), .r_valid(r_valid), .dout(dout),
        .bias_out(bias_out), .cfg_out(cfg_out), .is_3x3(is_3x3)
    );

    // mid-cycle, after inputs and DUT outputs have settled
    always @(posedge clk) begin
        #1.5;
        if (rstn) begin
            if (l_take && l_bias) begin   // group closes, replay rot + 1 times
                for (int p = 0; p <= int'(l_rot); p++) begin
                    foreach (grp_q[i]) exp_q.push_back(grp_q[i]);
                end
                grp_q.delete();
                exp_bias = l_line;
                exp_cfg  = l_cfg;
                l_idx    = 0;
            end else if (l_take) begin
                grp_q.push_back(l_line);
                l_idx++;
            end
            if (r_take) begin
                out_cnt++;                // every handshake on dout
                if (exp_q.size() != 0) begin
                    void'(exp_q.pop_front());
                end
            end
        end
        l_take     = rstn && l_valid && l_rdy;   // lands on the next edge
        l_bias     = (l_idx == int'(write_depth));
        l_line     = din;
        l_rot      = rotate_amount;
        l_cfg      = cfg_in;
        r_take     = rstn && r_valid && r_rdy;
        stall_prev = stall_cur;
        dout_prev  = dout_cur;
        stall_cur  = rstn && r_valid && !r_rdy;
        dout_cur   = dout;
        exp_cnt    = exp_q.size();
        exp_head   = (exp_cnt != 0) ? exp_q[0] : '0;
    end

    // r_rdy drawn at the falling edge, driven after the rising one
    always @(negedge clk) rdy_next = rand_rdy ? 1'($random(seed)) : 1'b1;
    always @(posedge clk) begin
        #0.5;
        r_rdy = rdy_next;
    end

    ////////////////////
    // checks
    ////////////////////

    task automatic log_error(input string msg);
        $display("%s", msg);
        err_cnt++;
    endtask

    a_reset: assert property (@(negedge clk) !rstn |-> !r_valid && l_rdy)
        else log_error($sformatf("mismatch r_valid, l_rdy in reset: got %h, %h expected 0, 1",
                                 r_valid, l_rdy));
    a_extra: assert property (@(negedge clk) disable iff (!rstn) r_valid |-> exp_cnt != 0)
        else log_error("r_valid high with no line left to deliver");
    a_gap: assert property (@(negedge clk) disable iff (!rstn) exp_cnt != 0 |-> r_valid)
        else log_error($sformatf("r_valid low while %0d lines are still due", exp_cnt));
    a_dout: assert property (@(negedge clk) disable iff (!rstn)
                             r_valid && exp_cnt != 0 |-> dout == exp_head)
        else log_error($sformatf("mismatch dout: got %h expected %h", dout, exp_head));
    a_hold: assert property (@(negedge clk) disable iff (!rstn) stall_prev |-> dout == dout_prev)
        else log_error($sformatf("mismatch dout under stall: got %h expected %h",
                                 dout, dout_prev));
    a_l_rdy_low: assert property (@(negedge clk) disable iff (!rstn)
                                  !l_rdy |-> l_idx == int'(write_depth) && exp_cnt != 0)
        else log_error("l_rdy low with no bias line waiting on the read bank");
    a_l_rdy_high: assert property (@(negedge clk) disable iff (!rstn)
                                   l_idx == int'(write_depth) && exp_cnt == 0 |-> l_rdy)
        else log_error("l_rdy low although the read bank has drained");
    a_bias: assert property (@(negedge clk) bias_out == exp_bias)
        else log_error($sformatf("mismatch bias_out: got %h expected %h",
                                 bias_out, exp_bias));
    a_cfg: assert property (@(negedge clk) cfg_out == exp_cfg)
        else log_error($sformatf("mismatch cfg_out: got %h expected %h",
                                 cfg_out, exp_cfg));
    a_3x3: assert property (@(negedge clk) is_3x3 == !exp_cfg.conv_mode)
        else log_error($sformatf("mismatch is_3x3: got %h expected %h",
                                 is_3x3, !exp_cfg.conv_mode));

    ////////////////////
    // stimulus
    ////////////////////

    function automatic weight_line_t random_line();
        weight_line_t w;
        for (int i = 0; i < `WR_CONV_CORES * `WR_LANES; i++) begin
            w[i] = weight_t'($random(seed));
        end
        return w;
    endfunction

    // called 0.5 ns after an edge, returns 0.5 ns after the accepting edge
    task automatic send_line(input weight_line_t line);
        logic done;
        din     = line;
        l_valid = 1'b1;
        done    = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = l_rdy;              // decides the coming edge
            @(posedge clk);
            #0.5;
        end
        l_valid = 1'b0;
    endtask

    task automatic load_group(input logic [`WR_ADDR_WIDTH-1:0] depth,
                              input logic [`WR_ROTATE_WIDTH-1:0] rot, input layer_cfg_t cfg);
        write_depth = depth;
        for (int i = 0; i < int'(depth); i++) begin
            send_line(random_line());
        end
        rotate_amount = rot;           // side-band rides with the bias line
        cfg_in        = cfg;
        send_line(random_line());
    endtask

    task automatic wait_drain();
        do @(negedge clk); while (exp_cnt != 0);
        repeat (4) @(posedge clk);     // r_valid must stay low here
        #0.5;
    endtask

    task automatic check_count(input int expected);
        assert (out_cnt == expected)
        else log_error($sformatf("mismatch out_cnt: got %h expected %h", out_cnt, expected));
    endtask

    task automatic report_test(input string name);
        n_tests++;
        if (err_cnt != errs_at_start) begin
            n_failed++;
            $display("test %0d %s: failed, %0d errors", n_tests, name, err_cnt - errs_at_start);
        end else begin
            $display("test %0d %s: ok", n_tests, name);
        end
        errs_at_start = err_cnt;
        out_cnt       = 0;
    endtask

    initial begin
        layer_cfg_t cfg_a;
        layer_cfg_t cfg_b;
        din           = '0;
        l_valid       = 1'b0;
        write_depth   = 6;
        rotate_amount = '0;
        cfg_in        = '0;
        r_rdy         = 1'b1;
        rand_rdy      = 1'b0;
        rdy_next      = 1'b1;
        l_take        = 1'b0;
        r_take        = 1'b0;
        stall_cur     = 1'b0;
        stall_prev    = 1'b0;
        exp_cnt       = 0;
        exp_head      = '0;
        exp_bias      = '0;
        l_idx         = 0;
        out_cnt       = 0;
        err_cnt       = 0;
        errs_at_start = 0;
        n_tests       = 0;
        n_failed      = 0;
        exp_cfg = '0;
        exp_cfg.max_mode = 1'b1;       // reset value of cfg_out
        cfg_a = '{channels: 10'd63, width: 9'd27, blocks: 5'd3,
                  conv_mode: 1'b0, max_mode: 1'b1};
        cfg_b = '{channels: 10'd511, width: 9'd13, blocks: 5'd1,
                  conv_mode: 1'b1, max_mode: 1'b0};

        @(posedge rstn);
        repeat (2) @(posedge clk);
        #0.5;
        report_test("reset state");

        load_group(6, 2, cfg_a);       // 0..5 three times
        wait_drain();
        check_count(6 * 3);
        report_test("single group");

        load_group(5, 1, cfg_b);       // new side-band, is_3x3 low
        wait_drain();
        check_count(5 * 2);
        report_test("side-band latching");

        load_group(7, 3, cfg_a);
        load_group(5, 1, cfg_b);       // bias waits for the first replay
        wait_drain();
        check_count(7 * 4 + 5 * 2);
        report_test("ping-pong");

        rand_rdy = 1'b1;
        load_group(6, 1, cfg_b);
        load_group(5, 2, cfg_a);
        wait_drain();
        rand_rdy = 1'b0;
        check_count(6 * 2 + 5 * 3);
        report_test("back-pressure");

        $display("tests run %0d, tests failed %0d, errors %0d", n_tests, n_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Test failures found");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+include
hdl/weight_rotator_pkg.sv
hdl/weight_ram.sv
hdl/weight_fifo.sv
hdl/weight_rotator.sv
verification/tb_clock_gen.sv
verification/tb_weight_rotator.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_weight_rotator -o sim_weight_rotator

out=$(./obj_dir/sim_weight_rotator)
echo "$out"
echo "$out" | grep -q "All tests passed!"
